// ==== common/fetchPkg.sv ====
/*
 * Fetch-side types for the four-lane next-fetch predictor.
 * Groups are 16-byte aligned; vAddr bits 3:2 select the start lane.
 */
`default_nettype none

package fetchPkg;

    // ----------------------------------------
    // Group geometry
    // ----------------------------------------
    localparam int LANES = 4;                      // Instructions per fetch group
    localparam int LANE_BITS = $clog2(LANES);      // Lane index width
    localparam logic [31:0] GROUP_BYTES = 32'd16;  // Bytes per group
    localparam logic [31:0] RESET_VADDR = 32'hBFC00000; // Boot vector

    // Group handed from the PC generator to the BTB
    typedef struct packed {
        logic [31:0]      vAddr;        // First wanted instruction
        logic [LANES-1:0] laneEn;       // Wanted lanes
        logic             isDelaySlot;  // Lone delay-slot fetch
    } fetchGroup_t;

    // Lookup result for one group
    typedef struct packed {
        logic [31:0]      nextVAddr;     // Next fetch address
        logic             taken;         // Taken branch selected
        logic [LANES-1:0] useEn;         // Lanes actually delivered
        logic             needDelaySlot; // Slot falls past lane 3
    } prediction_t;

    // Lanes from the start lane up to the last one
    function automatic logic [LANES-1:0] startMask(input logic [LANE_BITS-1:0] startLane);
        startMask = {LANES{1'b1}} << startLane;
    endfunction

    // Start lane alone, used for delay-slot groups
    function automatic logic [LANES-1:0] singleLane(input logic [LANE_BITS-1:0] startLane);
        singleLane = {{(LANES-1){1'b0}}, 1'b1} << startLane;
    endfunction

endpackage

`default_nettype wire

// ==== common/repairPkg.sv ====
/*
 * Backend repair request, a one-cycle strobe on valid.
 * Redirect and BTB write share one request.
 */
`default_nettype none

package repairPkg;

    // ----------------------------------------
    // Repair request from the backend
    // ----------------------------------------
    typedef struct packed {
        logic        valid;          // Strobe, one cycle
        logic        updateBtb;      // Rewrite the BTB entry too
        logic        taken;          // Resolved direction, becomes valid bit
        logic [31:0] branchVAddr;    // Branch that resolved
        logic [31:0] correctDest;    // Resolved target
        logic [31:0] redirectVAddr;  // Fetch restarts here
    } repairReq_t;

endpackage

`default_nettype wire

// ==== btb/branchFourToOne.sv ====
/*
 * Picks the lowest enabled lane with a BTB hit.
 * Delay-slot groups never predict. Lane 3 branches defer their slot.
 */
`timescale 1ns/100ps
`default_nettype none

module branchFourToOne (
    input  wire logic [fetchPkg::LANES-1:0]       laneEn_i,
    input  wire logic [fetchPkg::LANES-1:0]       hit_i,
    input  wire logic [fetchPkg::LANES-1:0][31:0] dest_i,
    input  wire logic [31:0]                      fifthVAddr_i,
    input  wire logic                             isDelaySlot_i,
    output fetchPkg::prediction_t                 pred_o
);

    localparam int LAST_LANE = fetchPkg::LANES - 1;

    logic [fetchPkg::LANES-1:0]     hitMask;   // Hits that count
    logic                           found;
    logic [fetchPkg::LANE_BITS-1:0] brLane;    // First taken lane
    logic [fetchPkg::LANES-1:0]     keepMask;  // Lanes up to branch plus slot

    // ----------------------------------------
    // First taken lane
    // ----------------------------------------
    always_comb begin
        hitMask = isDelaySlot_i ? '0 : (hit_i & laneEn_i);
        found   = 1'b0;
        brLane  = '0;
        // Lowest index wins
        for (int i = 0; i < fetchPkg::LANES; i++) begin
            if (hitMask[i] && !found) begin
                found  = 1'b1;
                brLane = fetchPkg::LANE_BITS'(i);
            end
        end
    end

    // ----------------------------------------
    // Delivered lanes
    // ----------------------------------------
    always_comb begin
        for (int j = 0; j < fetchPkg::LANES; j++) begin
            // Branch lane plus its slot up to the group edge
            keepMask[j] = !found || (j <= int'(brLane) + 1);
        end
    end

    always_comb begin
        pred_o.taken         = found;
        pred_o.useEn         = laneEn_i & keepMask;
        pred_o.needDelaySlot = found && (int'(brLane) == LAST_LANE);
        pred_o.nextVAddr     = found ? dest_i[brLane] : fifthVAddr_i;  // Fall through
    end

endmodule

`default_nettype wire

// ==== btb/branchTargetBuffer.sv ====
/*
 * Four-bank BTB, one bank per lane, looked up in parallel.
 * BTB_ENTRIES is a power of two >= 2; 4 + log2(BTB_ENTRIES) + TAG_BITS <= 32.
 * No direction counters; the valid bit is the taken prediction.
 */
`timescale 1ns/100ps
`default_nettype none

module branchTargetBuffer #(
    parameter int BTB_ENTRIES = 256,
    parameter int TAG_BITS    = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire fetchPkg::fetchGroup_t fetchGroup_i,
    input  wire repairPkg::repairReq_t repair_i,
    output fetchPkg::prediction_t      pred_o
);

    localparam int INDEX_BITS = $clog2(BTB_ENTRIES);
    localparam int TAG_LSB    = 4 + INDEX_BITS;   // Tag sits right above the index

    // ----------------------------------------
    // Lookup address split
    // ----------------------------------------
    logic [31:0]           groupBase;
    logic [31:0]           fifthVAddr;
    logic [INDEX_BITS-1:0] rdIdx;
    logic [TAG_BITS-1:0]   rdTag;

    assign groupBase  = {fetchGroup_i.vAddr[31:4], 4'b0000};
    assign fifthVAddr = groupBase + fetchPkg::GROUP_BYTES;       // First word of next group
    assign rdIdx      = fetchGroup_i.vAddr[4 +: INDEX_BITS];     // Same for every lane
    assign rdTag      = fetchGroup_i.vAddr[TAG_LSB +: TAG_BITS];

    // ----------------------------------------
    // Repair write decode
    // ----------------------------------------
    logic                             writeReq;
    logic [fetchPkg::LANE_BITS-1:0]   wrBank;
    logic [INDEX_BITS-1:0]            wrIdx;
    logic [TAG_BITS-1:0]              wrTag;

    assign writeReq = repair_i.valid && repair_i.updateBtb;
    assign wrBank   = repair_i.branchVAddr[3:2];             // Lane of the branch
    assign wrIdx    = repair_i.branchVAddr[4 +: INDEX_BITS];
    assign wrTag    = repair_i.branchVAddr[TAG_LSB +: TAG_BITS];

    // Per-lane lookup results
    logic [fetchPkg::LANES-1:0]         hit;
    logic [fetchPkg::LANES-1:0][31:0]   dest;

    // ----------------------------------------
    // Banks
    // ----------------------------------------
    for (genvar b = 0; b < fetchPkg::LANES; b++) begin : gBank
        logic [31:2]         targetMem [BTB_ENTRIES];
        logic [TAG_BITS-1:0] tagMem    [BTB_ENTRIES];
        logic [BTB_ENTRIES-1:0] validBits;
        logic                bankWe;

        assign bankWe = writeReq && (wrBank == fetchPkg::LANE_BITS'(b));

        // Valid bits are the only reset state
        always_ff @(posedge clk) begin
            if (!rst) begin
                validBits <= '0;
            end else if (bankWe) begin
                validBits[wrIdx] <= repair_i.taken;  // Not-taken repair kills the entry
            end
        end

        always_ff @(posedge clk) begin
            if (bankWe) begin
                targetMem[wrIdx] <= repair_i.correctDest[31:2];
                tagMem[wrIdx]    <= wrTag;
            end
        end

        assign hit[b]  = validBits[rdIdx] && (tagMem[rdIdx] == rdTag);
        assign dest[b] = {targetMem[rdIdx], 2'b00};
    end

    // ----------------------------------------
    // Lane selection
    // ----------------------------------------
    branchFourToOne uFourToOne (
        .laneEn_i      (fetchGroup_i.laneEn),
        .hit_i         (hit),
        .dest_i        (dest),
        .fifthVAddr_i  (fifthVAddr),
        .isDelaySlot_i (fetchGroup_i.isDelaySlot),  // Masks every hit
        .pred_o        (pred_o)
    );

    // Bank select must be clean whenever a write is requested
    wrBankKnown: assert property (
        @(posedge clk) disable iff (!rst)
        writeReq |-> !$isunknown(wrBank)
    ) else $error("BTB write with unknown bank index");

endmodule

`default_nettype wire

// ==== hdl/pcGenerator.sv ====
/*
 * Fetch group register and held delay-slot target.
 * Repair beats stall; stall holds the group unchanged.
 */
`timescale 1ns/100ps
`default_nettype none

module pcGenerator (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  fetchEn_i,
    input  wire repairPkg::repairReq_t repair_i,
    input  wire fetchPkg::prediction_t pred_i,
    output fetchPkg::fetchGroup_t      fetchGroup_o
);

    fetchPkg::fetchGroup_t nextGroup;
    logic [31:0]           groupBase;
    logic [31:0]           pendTarget;   // Branch target behind the delay slot
    logic                  loadPend;

    assign groupBase = {fetchGroup_o.vAddr[31:4], 4'b0000};

    // ----------------------------------------
    // Next group select
    // ----------------------------------------
    always_comb begin
        nextGroup = fetchGroup_o;   // Hold by default
        loadPend  = 1'b0;
        if (repair_i.valid) begin
            // Redirect drops any held slot
            nextGroup.vAddr       = repair_i.redirectVAddr;
            nextGroup.laneEn      = fetchPkg::startMask(repair_i.redirectVAddr[3:2]);
            nextGroup.isDelaySlot = 1'b0;
        end else if (fetchEn_i) begin
            if (fetchGroup_o.isDelaySlot) begin
                // After the slot go to the held target
                nextGroup.vAddr       = pendTarget;
                nextGroup.laneEn      = fetchPkg::startMask(pendTarget[3:2]);
                nextGroup.isDelaySlot = 1'b0;
            end else if (pred_i.needDelaySlot) begin
                // Lane 3 branch fetches its slot alone
                nextGroup.vAddr       = groupBase + fetchPkg::GROUP_BYTES;
                nextGroup.laneEn      = fetchPkg::singleLane(2'b00);
                nextGroup.isDelaySlot = 1'b1;
                loadPend              = 1'b1;
            end else begin
                nextGroup.vAddr       = pred_i.nextVAddr;
                nextGroup.laneEn      = fetchPkg::startMask(pred_i.nextVAddr[3:2]);
                nextGroup.isDelaySlot = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            fetchGroup_o.vAddr       <= fetchPkg::RESET_VADDR;
            fetchGroup_o.laneEn      <= '1;
            fetchGroup_o.isDelaySlot <= 1'b0;
        end else begin
            fetchGroup_o <= nextGroup;
        end
    end

    // Only read while a delay-slot group is live
    always_ff @(posedge clk) begin
        if (loadPend) begin
            pendTarget <= pred_i.nextVAddr;
        end
    end

    // Every group wants at least one lane
    laneEnNonZero: assert property (
        @(posedge clk) disable iff (!rst)
        fetchGroup_o.laneEn != '0
    ) else $error("Fetch group with no lanes enabled");

endmodule

`default_nettype wire

// ==== hdl/fetchPredictTop.sv ====
/*
 * Next-fetch predictor top. fetchGroup_o is registered,
 * pred_o is combinational from it in the same cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module fetchPredictTop #(
    parameter int BTB_ENTRIES = 256,   // Entries per bank
    parameter int TAG_BITS    = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  fetchEn_i,
    input  wire repairPkg::repairReq_t repair_i,
    output fetchPkg::fetchGroup_t      fetchGroup_o,
    output fetchPkg::prediction_t      pred_o
);

    fetchPkg::fetchGroup_t fetchGroup;
    fetchPkg::prediction_t pred;

    // ----------------------------------------
    // PC side
    // ----------------------------------------
    pcGenerator uPcGen (
        .clk          (clk),
        .rst          (rst),
        .fetchEn_i    (fetchEn_i),
        .repair_i     (repair_i),     // Redirect fields
        .pred_i       (pred),
        .fetchGroup_o (fetchGroup)
    );

    // ----------------------------------------
    // Prediction side
    // ----------------------------------------
    branchTargetBuffer #(
        .BTB_ENTRIES (BTB_ENTRIES),
        .TAG_BITS    (TAG_BITS)
    ) uBtb (
        .clk          (clk),
        .rst          (rst),
        .fetchGroup_i (fetchGroup),
        .repair_i     (repair_i),     // Write fields
        .pred_o       (pred)
    );

    assign fetchGroup_o = fetchGroup;
    assign pred_o       = pred;

endmodule

`default_nettype wire

// ==== dv/clkGen.sv ====
/*
 * Testbench clock and active-low reset.
 * Reset releases 1 ns after the last reset edge.
 */
`timescale 1ns/100ps
`default_nettype none

module clkGen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;   // Free running
    end

    initial begin
        rst_o = 1'b0;                               // Held from time zero
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b1;                               // Clear of the edge
    end

endmodule

`default_nettype wire

// ==== dv/fetchPredictTb.sv ====
/*
 * Testbench for fetchPredictTop against a shadow BTB model.
 * DUT built with 16 entries and 4 tag bits; random addresses stay in a 2 KB region.
 */
`timescale 1ns/100ps
`default_nettype none

module fetchPredictTb;

    localparam int ENTRIES = 16;
    localparam int TAGW    = 4;
    localparam int IDXW    = $clog2(ENTRIES);
    localparam repairPkg::repairReq_t NO_REPAIR = '0;

    logic                  clk;
    logic                  rst;
    logic                  fetchEn;
    repairPkg::repairReq_t repair;
    fetchPkg::fetchGroup_t fetchGroup;
    fetchPkg::prediction_t pred;

    // Shadow BTB and PC
    logic [31:0]           mTarget [4][ENTRIES];
    logic [TAGW-1:0]       mTag    [4][ENTRIES];
    logic                  mValid  [4][ENTRIES];
    fetchPkg::fetchGroup_t mGroup;
    logic [31:0]           mPend;                  // Target behind a delay slot

    string curTest;
    int    checks;
    int    errors;
    int    testsRun;
    int    testsBad;
    int    testStartErr;

    clkGen #(.PERIOD_NS(8), .RESET_CYCLES(10)) uClk (.clk_o(clk), .rst_o(rst));

    fetchPredictTop #(.BTB_ENTRIES(ENTRIES), .TAG_BITS(TAGW)) DUT (
        .clk          (clk),
        .rst          (rst),
        .fetchEn_i    (fetchEn),
        .repair_i     (repair),
        .fetchGroup_o (fetchGroup),
        .pred_o       (pred)
    );

    // ----------------------------------------
    // Model
    // ----------------------------------------
    function automatic logic [3:0] lanesFrom(input logic [1:0] start);
        logic [3:0] m;
        for (int i = 0; i < 4; i++) begin
            m[i] = (i >= int'(start));
        end
        return m;
    endfunction

    function automatic logic [31:0] regionAddr();
        return 32'h8000_0000 | ($urandom & 32'h0000_07FC);   // Word aligned within 2 KB
    endfunction

    function automatic fetchPkg::prediction_t expectPred(input fetchPkg::fetchGroup_t g);
        fetchPkg::prediction_t p;
        int   idx;
        int   tag;
        int   lane;
        logic found;
        idx   = (g.vAddr >> 4) & (ENTRIES - 1);
        tag   = (g.vAddr >> (4 + IDXW)) & ((1 << TAGW) - 1);
        found = 1'b0;
        lane  = 0;
        for (int i = 0; i < 4; i++) begin
            // First enabled hit and none in a delay-slot group
            if (!found && !g.isDelaySlot && g.laneEn[i] && mValid[i][idx]
                && mTag[i][idx] == tag) begin
                found = 1'b1;
                lane  = i;
            end
        end
        p.taken         = found;
        p.needDelaySlot = found && lane == 3;
        for (int j = 0; j < 4; j++) begin
            p.useEn[j] = g.laneEn[j] && (!found || j <= lane + 1);   // Branch plus slot
        end
        p.nextVAddr = found ? {mTarget[lane][idx][31:2], 2'b00}
                            : {g.vAddr[31:4], 4'b0000} + 32'd16;
        return p;
    endfunction

    function automatic void advanceModel(input logic en, input repairPkg::repairReq_t r);
        fetchPkg::prediction_t p;
        fetchPkg::fetchGroup_t nxt;
        int bank;
        int idx;
        p   = expectPred(mGroup);
        nxt = mGroup;                               // Stall holds
        if (r.valid) begin
            nxt = '{r.redirectVAddr, lanesFrom(r.redirectVAddr[3:2]), 1'b0};
        end else if (en && mGroup.isDelaySlot) begin
            nxt = '{mPend, lanesFrom(mPend[3:2]), 1'b0};
        end else if (en && p.needDelaySlot) begin
            nxt   = '{{mGroup.vAddr[31:4], 4'b0000} + 32'd16, 4'b0001, 1'b1};
            mPend = p.nextVAddr;
        end else if (en) begin
            nxt = '{p.nextVAddr, lanesFrom(p.nextVAddr[3:2]), 1'b0};
        end
        // Write lands with the redirect
        if (r.valid && r.updateBtb) begin
            bank = r.branchVAddr[3:2];
            idx  = (r.branchVAddr >> 4) & (ENTRIES - 1);
            mValid[bank][idx]  = r.taken;
            mTarget[bank][idx] = r.correctDest;
            mTag[bank][idx]    = TAGW'(r.branchVAddr >> (4 + IDXW));
        end
        mGroup = nxt;
    endfunction

    // ----------------------------------------
    // Stimulus and checks
    // ----------------------------------------
    function automatic repairPkg::repairReq_t makeRepair(input logic upd, input logic tkn,
            input logic [31:0] br, input logic [31:0] dst, input logic [31:0] redir);
        return '{1'b1, upd, tkn, br, dst, redir};
    endfunction

    function automatic repairPkg::repairReq_t randomRepair();
        repairPkg::repairReq_t r;
        r = makeRepair(($urandom % 10) < 7, ($urandom % 4) != 0, regionAddr(),
                       regionAddr(), regionAddr());
        r.valid = ($urandom % 10) == 0;             // About one cycle in ten
        return r;
    endfunction

    task automatic checkVal(input string name, input logic [63:0] exp,
                            input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $finish;
    endtask

    // Drive 1 ns after the edge then compare mid cycle and advance the model
    task automatic stepCycle(input logic en, input repairPkg::repairReq_t r);
        @(posedge clk);
        #1;
        fetchEn = en;
        repair  = r;
        #4;
        checkVal({curTest, " group"}, 64'(mGroup), 64'(fetchGroup));
        checkVal({curTest, " pred"}, 64'(expectPred(mGroup)), 64'(pred));
        advanceModel(en, r);
    endtask

    task automatic beginTest(input string name);
        curTest      = name;
        testStartErr = errors;
    endtask

    task automatic endTest();
        testsRun++;
        if (errors != testStartErr) begin
            testsBad++;
        end
        $display("test %s finished with %0d mismatches", curTest, errors - testStartErr);
    endtask

    // Last resort against a stuck run
    initial begin
        #200_000;
        abortRun("simulation watchdog expired");
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int                    waitCnt;
        logic [31:0]           br;
        logic [31:0]           dst;
        logic [3:0]            expEn;
        fetchPkg::fetchGroup_t held;
        void'($urandom(32'hdd3));
        fetchEn  = 1'b0;
        repair   = NO_REPAIR;
        checks   = 0;
        errors   = 0;
        testsRun = 0;
        testsBad = 0;
        for (int b = 0; b < 4; b++) begin
            for (int e = 0; e < ENTRIES; e++) begin
                mValid[b][e]  = 1'b0;
                mTarget[b][e] = '0;
                mTag[b][e]    = '0;
            end
        end
        waitCnt = 0;
        while (rst !== 1'b1) begin
            @(negedge clk);
            waitCnt++;
            if (waitCnt > 40) begin
                abortRun("reset was never released");
            end
        end
        mGroup = '{32'hBFC0_0000, 4'b1111, 1'b0};   // Boot vector with all lanes
        mPend  = '0;

        beginTest("reset");
        stepCycle(1'b0, NO_REPAIR);
        checkVal("reset vAddr", 32'hBFC0_0000, fetchGroup.vAddr);
        checkVal("reset laneEn", 4'b1111, fetchGroup.laneEn);
        checkVal("reset nextVAddr", 32'hBFC0_0010, pred.nextVAddr);
        repeat (6) begin
            stepCycle(1'b1, NO_REPAIR);
            checkVal("empty BTB taken", 1'b0, pred.taken);
        end
        endTest();

        beginTest("btbWrite");
        for (int i = 0; i < 3; i++) begin
            br  = 32'h8000_0100 + 32'h24 * i;       // Lane i with its own index
            dst = 32'h8000_0600 + 32'h40 * i;
            stepCycle(1'b0, makeRepair(1'b1, 1'b1, br, dst, {br[31:4], 4'b0000}));
            stepCycle(1'b0, NO_REPAIR);
            for (int j = 0; j < 4; j++) begin
                expEn[j] = (j <= i + 1);
            end
            checkVal("hit target", dst, pred.nextVAddr);
            checkVal("hit useEn", expEn, pred.useEn);
        end
        endTest();

        beginTest("laneThree");
        stepCycle(1'b0, makeRepair(1'b1, 1'b1, 32'h8000_020C, 32'h8000_0588, 32'h8000_0200));
        stepCycle(1'b1, NO_REPAIR);
        checkVal("lane3 needDelaySlot", 1'b1, pred.needDelaySlot);
        waitCnt = 0;
        while (!fetchGroup.isDelaySlot) begin
            stepCycle(1'b1, NO_REPAIR);
            waitCnt++;
            if (waitCnt > 8) begin
                abortRun("delay-slot group never appeared");
            end
        end
        checkVal("slot vAddr", 32'h8000_0210, fetchGroup.vAddr);
        checkVal("slot laneEn", 4'b0001, fetchGroup.laneEn);
        stepCycle(1'b1, NO_REPAIR);
        checkVal("after slot vAddr", 32'h8000_0588, fetchGroup.vAddr);
        checkVal("after slot laneEn", 4'b1100, fetchGroup.laneEn);
        endTest();

        beginTest("missCases");
        stepCycle(1'b0, makeRepair(1'b1, 1'b0, 32'h8000_020C, 32'h8000_0588, 32'h8000_0200));
        stepCycle(1'b0, NO_REPAIR);
        checkVal("cleared taken", 1'b0, pred.taken);
        checkVal("cleared nextVAddr", 32'h8000_0210, pred.nextVAddr);
        stepCycle(1'b0, makeRepair(1'b0, 1'b0, '0, '0, 32'h8000_0900));   // Tag 9 vs 1
        stepCycle(1'b0, NO_REPAIR);
        checkVal("tag miss taken", 1'b0, pred.taken);
        stepCycle(1'b0, makeRepair(1'b0, 1'b0, '0, '0, 32'h8000_0128));   // Lane 1 hit masked
        stepCycle(1'b0, NO_REPAIR);
        checkVal("unaligned laneEn", 4'b1100, fetchGroup.laneEn);
        checkVal("unaligned useEn", 4'b1100, pred.useEn);
        checkVal("disabled lane taken", 1'b0, pred.taken);
        endTest();

        beginTest("stallRedirect");
        held = '{32'h8000_0128, 4'b1100, 1'b0};     // Group left by the unaligned redirect
        repeat (4) begin
            stepCycle(1'b0, NO_REPAIR);
            checkVal("stall hold", held, fetchGroup);
        end
        stepCycle(1'b0, makeRepair(1'b0, 1'b0, '0, '0, 32'h8000_0340));
        stepCycle(1'b0, NO_REPAIR);
        checkVal("redirect in stall", 32'h8000_0340, fetchGroup.vAddr);
        stepCycle(1'b0, makeRepair(1'b1, 1'b1, 32'h8000_030C, 32'h8000_0700, 32'h8000_0300));
        stepCycle(1'b1, NO_REPAIR);
        stepCycle(1'b1, makeRepair(1'b0, 1'b0, '0, '0, 32'h8000_0480));
        checkVal("slot before redirect", 1'b1, fetchGroup.isDelaySlot);
        stepCycle(1'b1, NO_REPAIR);
        checkVal("redirect over slot", 32'h8000_0480, fetchGroup.vAddr);
        checkVal("slot dropped", 1'b0, fetchGroup.isDelaySlot);
        endTest();

        beginTest("randomMix");
        repeat (3000) begin
            stepCycle(($urandom % 5) != 0, randomRepair());
        end
        endTest();

        $display("tests %0d, failed tests %0d, checks %0d, mismatches %0d",
                 testsRun, testsBad, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
common/fetchPkg.sv
common/repairPkg.sv
btb/branchFourToOne.sv
btb/branchTargetBuffer.sv
hdl/pcGenerator.sv
hdl/fetchPredictTop.sv
dv/clkGen.sv
dv/fetchPredictTb.sv
